//--- logic/chip_consts.svh
`ifndef CHIP_CONSTS_SVH
`define CHIP_CONSTS_SVH

// Host link and buffer word width
`define PORT_DATAWIDTH 16

// Global buffer geometry
`define BUF_ADDRWIDTH 4
`define BUF_DEPTH 16

// Words written to one buffer before near_full is raised
`define NEAR_FULL_LEVEL 14

`endif

//--- logic/link_pkg.sv
package link_pkg;

    // ============================================================
    // Host link session phases
    // ============================================================

    // One session walks these in order and returns to ph_config
    typedef enum logic [2:0] {
        ph_config,
        ph_weight,
        ph_act,
        ph_compute,
        ph_read
    } link_phase_t;

endpackage

//--- logic/core_pkg.sv
`include "chip_consts.svh"

package core_pkg;

    // Data word shared by host link, buffers and datapath
    typedef logic signed [`PORT_DATAWIDTH-1:0] word_t;

    // Word count, one bit wider than an address to hold 16
    typedef logic [`BUF_ADDRWIDTH:0] len_t;

    // Opcode field of the config word, bits 15:12
    typedef enum logic [3:0] {
        op_mac      = 4'd1,
        op_mul      = 4'd2,
        op_relu_mac = 4'd3
    } opcode_t;

    typedef enum logic [2:0] {
        cs_idle,
        cs_read,
        cs_accum,
        cs_write,
        cs_done
    } core_state_t;

endpackage

//--- logic/global_buffer.sv
`include "chip_consts.svh"

module global_buffer (
    input  logic                      clk,
    input  logic                      en_wr,
    input  logic [`BUF_ADDRWIDTH-1:0] addr_wr,
    input  core_pkg::word_t           dat_wr,
    input  logic                      en_rd,
    input  logic [`BUF_ADDRWIDTH-1:0] addr_rd,
    output core_pkg::word_t           dat_rd
);

    core_pkg::word_t mem [`BUF_DEPTH];

    // Write lands on the enabled edge
    always_ff @(posedge clk) begin
        if (en_wr) begin
            mem[addr_wr] <= dat_wr;
        end
    end

    // Registered read, data one cycle after en_rd
    always_ff @(posedge clk) begin
        if (en_rd) begin
            dat_rd <= mem[addr_rd];
        end
    end

endmodule

//--- logic/host_link.sv
`include "chip_consts.svh"

module host_link (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sck,
    input  logic                      cs_n,
    input  logic                      oe_req,
    input  core_pkg::word_t           data_in,
    output core_pkg::word_t           data_out,
    output logic                      data_oe,
    output logic                      config_req,
    output logic                      near_full,
    output logic                      switch_rdwr,
    output logic                      wei_en_wr,
    output logic [`BUF_ADDRWIDTH-1:0] wei_addr_wr,
    output core_pkg::word_t           wei_dat_wr,
    output logic                      act_en_wr,
    output logic [`BUF_ADDRWIDTH-1:0] act_addr_wr,
    output core_pkg::word_t           act_dat_wr,
    output logic                      ofm_en_rd,
    output logic [`BUF_ADDRWIDTH-1:0] ofm_addr_rd,
    input  core_pkg::word_t           ofm_dat_rd,
    output logic                      start,
    output core_pkg::opcode_t         opcode,
    output core_pkg::len_t            length,
    input  logic                      done,
    input  core_pkg::len_t            result_count
);

    link_pkg::link_phase_t phase;
    core_pkg::len_t        wr_cnt;
    core_pkg::len_t        wr_nxt;
    core_pkg::len_t        rd_cnt;
    core_pkg::len_t        rd_nxt;
    logic                  strobe;
    logic                  wr_last;
    logic                  rd_last;
    logic                  rd_kick;
    logic                  ofm_ld;

    // ============================================================
    // Host strobe and buffer write port
    // ============================================================

    // One word per sck pulse while selected
    assign strobe  = sck && !cs_n;
    assign wr_nxt  = wr_cnt + 1'b1;
    assign wr_last = wr_nxt == length;
    assign rd_nxt  = rd_cnt + 1'b1;
    assign rd_last = rd_nxt == result_count;

    assign wei_en_wr   = strobe && (phase == link_pkg::ph_weight);
    assign wei_addr_wr = wr_cnt[`BUF_ADDRWIDTH-1:0];
    assign wei_dat_wr  = data_in;

    assign act_en_wr   = strobe && (phase == link_pkg::ph_act);
    assign act_addr_wr = wr_cnt[`BUF_ADDRWIDTH-1:0];
    assign act_dat_wr  = data_in;

    // Warn the host as the current buffer fills up
    assign near_full = ((phase == link_pkg::ph_weight) || (phase == link_pkg::ph_act))
                       && (wr_cnt >= core_pkg::len_t'(`NEAR_FULL_LEVEL));

    // First result is fetched on entry to the read phase, the rest on each sck
    assign ofm_en_rd   = rd_kick || (strobe && (phase == link_pkg::ph_read) && !rd_last);
    assign ofm_addr_rd = rd_kick ? '0 : rd_nxt[`BUF_ADDRWIDTH-1:0];

    // ============================================================
    // Session sequencer
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= link_pkg::ph_config;
            config_req  <= 1'b1;
            switch_rdwr <= 1'b0;
            start       <= 1'b0;
            rd_kick     <= 1'b0;
            wr_cnt      <= '0;
            rd_cnt      <= '0;
            opcode      <= core_pkg::op_mac;
            length      <= '0;
        end else begin
            start   <= 1'b0;
            rd_kick <= 1'b0;
            case (phase)
                link_pkg::ph_config: begin
                    if (strobe) begin
                        opcode     <= core_pkg::opcode_t'(data_in[`PORT_DATAWIDTH-1 -: 4]);
                        length     <= data_in[`BUF_ADDRWIDTH:0];
                        wr_cnt     <= '0;
                        config_req <= 1'b0;
                        phase      <= link_pkg::ph_weight;
                    end
                end
                link_pkg::ph_weight: begin
                    if (strobe) begin
                        if (wr_last) begin
                            wr_cnt <= '0;
                            phase  <= link_pkg::ph_act;
                        end else begin
                            wr_cnt <= wr_nxt;
                        end
                    end
                end
                link_pkg::ph_act: begin
                    if (strobe) begin
                        if (wr_last) begin
                            wr_cnt <= '0;
                            start  <= 1'b1;
                            phase  <= link_pkg::ph_compute;
                        end else begin
                            wr_cnt <= wr_nxt;
                        end
                    end
                end
                link_pkg::ph_compute: begin
                    // Hand the pad over to the host for readback
                    if (done) begin
                        switch_rdwr <= 1'b1;
                        rd_kick     <= 1'b1;
                        rd_cnt      <= '0;
                        phase       <= link_pkg::ph_read;
                    end
                end
                link_pkg::ph_read: begin
                    if (strobe) begin
                        if (rd_last) begin
                            switch_rdwr <= 1'b0;
                            config_req  <= 1'b1;
                            phase       <= link_pkg::ph_config;
                        end else begin
                            rd_cnt <= rd_nxt;
                        end
                    end
                end
                default: begin
                    phase <= link_pkg::ph_config;
                end
            endcase
        end
    end

    // ============================================================
    // Result output and pad turnaround
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ofm_ld   <= 1'b0;
            data_out <= '0;
            data_oe  <= 1'b0;
        end else begin
            ofm_ld  <= ofm_en_rd;
            // Pad drives one cycle after the request
            data_oe <= switch_rdwr && oe_req;
            if (ofm_ld) begin
                data_out <= ofm_dat_rd;
            end
        end
    end

endmodule

//--- logic/mac_core.sv
`include "chip_consts.svh"

module mac_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  core_pkg::opcode_t         opcode,
    input  core_pkg::len_t            length,
    output logic                      done,
    output core_pkg::len_t            result_count,
    output logic                      wei_en_rd,
    output logic [`BUF_ADDRWIDTH-1:0] wei_addr_rd,
    output logic                      act_en_rd,
    output logic [`BUF_ADDRWIDTH-1:0] act_addr_rd,
    input  core_pkg::word_t           wei_dat_rd,
    input  core_pkg::word_t           act_dat_rd,
    output logic                      ofm_en_wr,
    output logic [`BUF_ADDRWIDTH-1:0] ofm_addr_wr,
    output core_pkg::word_t           ofm_dat_wr
);

    core_pkg::core_state_t     state;
    core_pkg::len_t            idx;
    core_pkg::len_t            idx_nxt;
    logic [`BUF_ADDRWIDTH-1:0] prod_idx;
    core_pkg::word_t           prod;
    logic                      prod_vld;
    core_pkg::word_t           acc;
    core_pkg::word_t           sum;
    core_pkg::word_t           sum_clamp;
    logic                      is_mul;
    logic                      drain;

    assign is_mul  = opcode == core_pkg::op_mul;
    assign idx_nxt = idx + 1'b1;

    // Wrapping 16-bit sum including the pending product
    assign sum       = acc + prod;
    assign sum_clamp = ((opcode == core_pkg::op_relu_mac) && sum[`PORT_DATAWIDTH-1]) ?
                       '0 : sum;

    // Previous product is used up while the next pair is read
    assign drain = (state == core_pkg::cs_read) && prod_vld;

    // ============================================================
    // Buffer ports
    // ============================================================
    assign wei_en_rd   = state == core_pkg::cs_read;
    assign wei_addr_rd = idx[`BUF_ADDRWIDTH-1:0];
    assign act_en_rd   = state == core_pkg::cs_read;
    assign act_addr_rd = idx[`BUF_ADDRWIDTH-1:0];

    always_comb begin
        ofm_en_wr   = state == core_pkg::cs_write;
        ofm_addr_wr = '0;
        ofm_dat_wr  = sum_clamp;
        // Elementwise mode stores each product at its own index
        if (is_mul) begin
            ofm_en_wr   = drain || (state == core_pkg::cs_write);
            ofm_addr_wr = prod_idx;
            ofm_dat_wr  = prod;
        end
    end

    assign done         = state == core_pkg::cs_done;
    assign result_count = is_mul ? length : core_pkg::len_t'(1);

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= core_pkg::cs_idle;
            idx      <= '0;
            acc      <= '0;
            prod_vld <= 1'b0;
        end else begin
            case (state)
                core_pkg::cs_idle: begin
                    if (start) begin
                        idx      <= '0;
                        acc      <= '0;
                        prod_vld <= 1'b0;
                        state    <= core_pkg::cs_read;
                    end
                end
                core_pkg::cs_read: begin
                    if (drain && !is_mul) begin
                        acc <= sum;
                    end
                    prod_vld <= 1'b0;
                    state    <= core_pkg::cs_accum;
                end
                core_pkg::cs_accum: begin
                    prod_vld <= 1'b1;
                    if (idx_nxt == length) begin
                        state <= core_pkg::cs_write;
                    end else begin
                        idx   <= idx_nxt;
                        state <= core_pkg::cs_read;
                    end
                end
                core_pkg::cs_write: begin
                    prod_vld <= 1'b0;
                    state    <= core_pkg::cs_done;
                end
                core_pkg::cs_done: begin
                    state <= core_pkg::cs_idle;
                end
                default: begin
                    state <= core_pkg::cs_idle;
                end
            endcase
        end
    end

    // Product register, low half of the signed product
    always_ff @(posedge clk) begin
        if (state == core_pkg::cs_accum) begin
            prod     <= wei_dat_rd * act_dat_rd;
            prod_idx <= idx[`BUF_ADDRWIDTH-1:0];
        end
    end

endmodule

//--- logic/accel_top.sv
`include "chip_consts.svh"

module accel_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            sck,
    input  logic            cs_n,
    input  logic            oe_req,
    input  core_pkg::word_t data_in,
    output core_pkg::word_t data_out,
    output logic            data_oe,
    output logic            config_req,
    output logic            near_full,
    output logic            switch_rdwr
);

    // ============================================================
    // Buffer and core wiring
    // ============================================================
    logic                      wei_en_wr;
    logic [`BUF_ADDRWIDTH-1:0] wei_addr_wr;
    core_pkg::word_t           wei_dat_wr;
    logic                      wei_en_rd;
    logic [`BUF_ADDRWIDTH-1:0] wei_addr_rd;
    core_pkg::word_t           wei_dat_rd;
    logic                      act_en_wr;
    logic [`BUF_ADDRWIDTH-1:0] act_addr_wr;
    core_pkg::word_t           act_dat_wr;
    logic                      act_en_rd;
    logic [`BUF_ADDRWIDTH-1:0] act_addr_rd;
    core_pkg::word_t           act_dat_rd;
    logic                      ofm_en_wr;
    logic [`BUF_ADDRWIDTH-1:0] ofm_addr_wr;
    core_pkg::word_t           ofm_dat_wr;
    logic                      ofm_en_rd;
    logic [`BUF_ADDRWIDTH-1:0] ofm_addr_rd;
    core_pkg::word_t           ofm_dat_rd;
    logic                      start;
    logic                      done;
    core_pkg::opcode_t         opcode;
    core_pkg::len_t            length;
    core_pkg::len_t            result_count;

    host_link host_link_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (sck),
        .cs_n         (cs_n),
        .oe_req       (oe_req),
        .data_in      (data_in),
        .data_out     (data_out),
        .data_oe      (data_oe),
        .config_req   (config_req),
        .near_full    (near_full),
        .switch_rdwr  (switch_rdwr),
        .wei_en_wr    (wei_en_wr),
        .wei_addr_wr  (wei_addr_wr),
        .wei_dat_wr   (wei_dat_wr),
        .act_en_wr    (act_en_wr),
        .act_addr_wr  (act_addr_wr),
        .act_dat_wr   (act_dat_wr),
        .ofm_en_rd    (ofm_en_rd),
        .ofm_addr_rd  (ofm_addr_rd),
        .ofm_dat_rd   (ofm_dat_rd),
        .start        (start),
        .opcode       (opcode),
        .length       (length),
        .done         (done),
        .result_count (result_count)
    );

    mac_core mac_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .opcode       (opcode),
        .length       (length),
        .done         (done),
        .result_count (result_count),
        .wei_en_rd    (wei_en_rd),
        .wei_addr_rd  (wei_addr_rd),
        .act_en_rd    (act_en_rd),
        .act_addr_rd  (act_addr_rd),
        .wei_dat_rd   (wei_dat_rd),
        .act_dat_rd   (act_dat_rd),
        .ofm_en_wr    (ofm_en_wr),
        .ofm_addr_wr  (ofm_addr_wr),
        .ofm_dat_wr   (ofm_dat_wr)
    );

    // Written by the host link, read by the core
    global_buffer wei_buf (
        .clk     (clk),
        .en_wr   (wei_en_wr),
        .addr_wr (wei_addr_wr),
        .dat_wr  (wei_dat_wr),
        .en_rd   (wei_en_rd),
        .addr_rd (wei_addr_rd),
        .dat_rd  (wei_dat_rd)
    );

    global_buffer act_buf (
        .clk     (clk),
        .en_wr   (act_en_wr),
        .addr_wr (act_addr_wr),
        .dat_wr  (act_dat_wr),
        .en_rd   (act_en_rd),
        .addr_rd (act_addr_rd),
        .dat_rd  (act_dat_rd)
    );

    // Written by the core, read back by the host link
    global_buffer ofm_buf (
        .clk     (clk),
        .en_wr   (ofm_en_wr),
        .addr_wr (ofm_addr_wr),
        .dat_wr  (ofm_dat_wr),
        .en_rd   (ofm_en_rd),
        .addr_rd (ofm_addr_rd),
        .dat_rd  (ofm_dat_rd)
    );

endmodule

//--- test/accel_tb.sv
`include "chip_consts.svh"

module accel_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ============================================================
    // Run length and host pacing
    // ============================================================
    localparam int NUM_SESSIONS   = 12;
    // Budget per session well above the longest op_mul run
    localparam int SESSION_CYCLES = 600;
    localparam int TIMEOUT_CYCLES = (NUM_SESSIONS * SESSION_CYCLES * 5) / 2 + 2000;
    localparam int STROBE_GAP     = 3;

    typedef core_pkg::word_t word_arr_t [`BUF_DEPTH];

    // How operand words are picked for a session
    typedef enum {
        fill_random,
        fill_negative,
        fill_positive
    } fill_t;

    logic            clk;
    logic            rst_n;
    logic            sck;
    logic            cs_n;
    logic            oe_req;
    core_pkg::word_t data_in;
    core_pkg::word_t data_out;
    logic            data_oe;
    logic            config_req;
    logic            near_full;
    logic            switch_rdwr;

    core_pkg::word_t exp_q [$];
    core_pkg::word_t got_q [$];
    int              cycle_cnt = 0;
    int              n_rand;

    accel_top accel_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .sck         (sck),
        .cs_n        (cs_n),
        .oe_req      (oe_req),
        .data_in     (data_in),
        .data_out    (data_out),
        .data_oe     (data_oe),
        .config_req  (config_req),
        .near_full   (near_full),
        .switch_rdwr (switch_rdwr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ============================================================
    // Reference model and compare tasks
    // ============================================================

    // Expected result word idx of a session
    function automatic core_pkg::word_t ref_result(
        input core_pkg::opcode_t op,
        input word_arr_t         wv,
        input word_arr_t         av,
        input int                n,
        input int                idx
    );
        logic signed [31:0] prod;
        logic signed [31:0] total;
        core_pkg::word_t    low;
        if (op == core_pkg::op_mul) begin
            prod = wv[idx] * av[idx];
            low  = prod[`PORT_DATAWIDTH-1:0];
        end else begin
            total = '0;
            for (int k = 0; k < n; k++) begin
                prod  = wv[k] * av[k];
                total = total + prod;
            end
            // Relu looks at the sign of the wrapped 16-bit sum
            low = total[`PORT_DATAWIDTH-1:0];
            if ((op == core_pkg::op_relu_mac) && low[`PORT_DATAWIDTH-1]) begin
                low = '0;
            end
        end
        return low;
    endfunction

    task automatic check_word(input string name, input core_pkg::word_t got,
                              input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Result words read by the host against the reference
    always @(posedge clk) begin : compare_results
        core_pkg::word_t got;
        core_pkg::word_t exp;
        if (got_q.size() != 0) begin
            if (exp_q.size() == 0) begin
                $display("A result word was read with no expected value left");
                $display("Simulation failed");
                $fatal(1);
            end else begin
                got = got_q.pop_front();
                exp = exp_q.pop_front();
                check_word("data_out", got, exp);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering the host", cycle_cnt);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // ============================================================
    // Host model
    // ============================================================

    // Send one word on a single sck pulse
    // Returns at the falling edge after the sample
    task automatic strobe_word(input core_pkg::word_t w);
        @(posedge clk);
        sck     <= 1'b1;
        cs_n    <= 1'b0;
        data_in <= w;
        @(posedge clk);
        sck  <= 1'b0;
        cs_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic idle_gap();
        repeat (STROBE_GAP) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_config(input core_pkg::opcode_t op, input int n);
        core_pkg::word_t cfg;
        cfg = {op, 7'd0, core_pkg::len_t'(n)};
        while (!config_req) @(negedge clk);
        strobe_word(cfg);
        check_bit("config_req", config_req, 1'b0);
        idle_gap();
    endtask

    task automatic write_data(input link_pkg::link_phase_t ph, input core_pkg::word_t w,
                              input int k, input int n);
        logic exp_nf;
        strobe_word(w);
        // Last word moves on to a new buffer and clears the count
        exp_nf = ((k + 1) >= `NEAR_FULL_LEVEL) && ((k + 1) < n);
        check_bit($sformatf("near_full in %s", ph.name()), near_full, exp_nf);
        idle_gap();
    endtask

    task automatic read_results(input int count, input bit use_oe);
        while (!switch_rdwr) @(negedge clk);
        if (use_oe) begin
            // Pad stays off for a cycle with the switch up and oe_req low
            @(negedge clk);
            check_bit("data_oe", data_oe, 1'b0);
            @(posedge clk);
            oe_req <= 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_bit("data_oe", data_oe, 1'b1);
        end
        // First result word is loaded two cycles after the switch
        repeat (2) @(posedge clk);
        @(negedge clk);
        for (int k = 0; k < count; k++) begin
            check_bit("switch_rdwr", switch_rdwr, 1'b1);
            check_bit("data_oe", data_oe, use_oe);
            got_q.push_back(data_out);
            strobe_word('0);
            if (k < count - 1) begin
                idle_gap();
            end
        end
        check_bit("switch_rdwr", switch_rdwr, 1'b0);
        check_bit("config_req", config_req, 1'b1);
        if (use_oe) begin
            @(posedge clk);
            oe_req <= 1'b0;
            @(posedge clk);
            @(negedge clk);
            check_bit("data_oe", data_oe, 1'b0);
        end
        idle_gap();
    endtask

    function automatic core_pkg::word_t make_value(input fill_t mode, input bit is_act);
        core_pkg::word_t v;
        // Small magnitudes keep 16 products below the wrap point
        v = core_pkg::word_t'($urandom_range(40, 1));
        if (mode == fill_random) begin
            v = core_pkg::word_t'($urandom);
        end else if ((mode == fill_negative) && is_act) begin
            v = -v;
        end
        return v;
    endfunction

    task automatic run_session(input core_pkg::opcode_t op, input int n,
                               input fill_t mode, input bit use_oe);
        word_arr_t wv;
        word_arr_t av;
        int        count;
        for (int k = 0; k < `BUF_DEPTH; k++) begin
            wv[k] = make_value(mode, 1'b0);
            av[k] = make_value(mode, 1'b1);
        end
        count = (op == core_pkg::op_mul) ? n : 1;
        for (int k = 0; k < count; k++) begin
            exp_q.push_back(ref_result(op, wv, av, n, k));
        end
        write_config(op, n);
        for (int k = 0; k < n; k++) begin
            write_data(link_pkg::ph_weight, wv[k], k, n);
        end
        for (int k = 0; k < n; k++) begin
            write_data(link_pkg::ph_act, av[k], k, n);
        end
        read_results(count, use_oe);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        void'($urandom(32'h4d29_1bbf));
        rst_n    = 1'b0;
        sck      = 1'b0;
        cs_n     = 1'b1;
        oe_req   = 1'b0;
        data_in  = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        // Idle state after reset
        check_bit("config_req", config_req, 1'b1);
        check_bit("near_full", near_full, 1'b0);
        check_bit("switch_rdwr", switch_rdwr, 1'b0);
        check_bit("data_oe", data_oe, 1'b0);
        check_word("data_out", data_out, '0);

        run_session(core_pkg::op_mac, 1, fill_random, 1'b0);
        run_session(core_pkg::op_mac, 16, fill_random, 1'b1);
        for (int s = 0; s < 3; s++) begin
            n_rand = $urandom_range(16, 1);
            run_session(core_pkg::op_mac, n_rand, fill_random, 1'b0);
        end

        run_session(core_pkg::op_relu_mac, 16, fill_negative, 1'b0);
        run_session(core_pkg::op_relu_mac, 16, fill_positive, 1'b0);
        n_rand = $urandom_range(16, 1);
        run_session(core_pkg::op_relu_mac, n_rand, fill_random, 1'b1);

        // Full buffers exercise near_full in both write phases
        run_session(core_pkg::op_mul, 16, fill_random, 1'b0);
        n_rand = $urandom_range(16, 1);
        run_session(core_pkg::op_mul, n_rand, fill_random, 1'b1);
        run_session(core_pkg::op_mul, 1, fill_random, 1'b1);
        run_session(core_pkg::op_relu_mac, 9, fill_random, 1'b0);

        // Give the compare process time for the last word
        repeat (2) @(posedge clk);
        @(negedge clk);
        if ((got_q.size() != 0) || (exp_q.size() != 0)) begin
            $display("%0d expected result words were never checked", exp_q.size());
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+logic
logic/link_pkg.sv
logic/core_pkg.sv
logic/global_buffer.sv
logic/host_link.sv
logic/mac_core.sv
logic/accel_top.sv
test/accel_tb.sv

//--- Makefile
# Verilator build and run for the accelerator testbench

VERILATOR ?= verilator
TOP       ?= accel_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
